//--- logic/thumb_pkg.sv
package thumb_pkg;

    // width of a core word and of the generated immediate
    localparam int WORD = 32;

    // every Thumb instruction arrives as one halfword
    localparam int HALF_WORD = 16;

    // register index width covers r0 to r15
    localparam int REG_W = 4;

    // branch condition field width
    localparam int COND_W = 4;

    // fixed register indices used by SP and PC relative formats
    localparam logic [REG_W-1:0] REG_SP = 4'd13;
    localparam logic [REG_W-1:0] REG_PC = 4'd15;

    // width of the sign-extended BL offset before widening to WORD
    localparam int BL_OFFSET_W = 25;

    // width of the doubled conditional branch offset
    localparam int COND_OFFSET_W = 9;

    // width of the doubled unconditional branch offset
    localparam int UNCOND_OFFSET_W = 12;

    // instruction classes recognised by the decode front end
    typedef enum logic [4:0] {
        // lsl, lsr and asr with a 5-bit shift amount
        CLS_SHIFT_IMM,
        // add and sub with three low registers
        CLS_ADD_SUB_REG,
        // add and sub with a 3-bit immediate
        CLS_ADD_SUB_IMM3,
        // mov, cmp, add and sub with an 8-bit immediate
        CLS_IMM8,
        // register to register ALU operations
        CLS_DATA_PROC,
        // ldr from a PC relative literal
        CLS_LOAD_LIT,
        // load and store with a register offset
        CLS_LS_REG,
        // word load and store with a 5-bit immediate offset
        CLS_LS_WORD_IMM,
        // byte load and store with a 5-bit immediate offset
        CLS_LS_BYTE_IMM,
        // halfword load and store with a 5-bit immediate offset
        CLS_LS_HALF_IMM,
        // load and store relative to SP
        CLS_LS_SP,
        // address generation relative to PC
        CLS_ADR,
        // address generation relative to SP
        CLS_ADD_SP,
        // add or subtract an immediate to SP itself
        CLS_SP_ADJ,
        // conditional branch with an 8-bit offset
        CLS_COND_BRANCH,
        // unconditional branch with an 11-bit offset
        CLS_UNCOND_BRANCH,
        // first halfword of a branch with link
        CLS_BL_PREFIX,
        // second halfword of a branch with link, combined with its prefix
        CLS_BL,
        // a valid encoding outside the decoded subset
        CLS_OTHER,
        // a BL second halfword with no prefix in front of it
        CLS_ILLEGAL
    } instr_class_e;

    // one decoded instruction as it leaves the front end
    typedef struct packed {
        instr_class_e      cls;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rn;
        logic [REG_W-1:0]  rm;
        logic [COND_W-1:0] cond;
        logic [WORD-1:0]   imm;
    } decoded_t;

endpackage

//--- logic/thumb_imm_gen.sv
`timescale 1ns/1ns

module thumb_imm_gen (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [thumb_pkg::HALF_WORD-1:0] instr_i,
    input  logic                            instr_valid_i,
    input  thumb_pkg::instr_class_e         cls_i,
    output logic [thumb_pkg::WORD-1:0]      imm_o
);
    import thumb_pkg::*;

    // last halfword seen on a strobe, which is the prefix when a BL completes
    logic [HALF_WORD-1:0]       prefix_q;

    logic                       bl_s;
    logic                       bl_i1;
    logic                       bl_i2;
    logic [BL_OFFSET_W-1:0]     bl_offset;
    logic [COND_OFFSET_W-1:0]   cond_offset;
    logic [UNCOND_OFFSET_W-1:0] uncond_offset;

    // branch offsets are halfword aligned so the low bit is always zero
    always_comb begin
        bl_s          = prefix_q[10];
        bl_i1         = ~(instr_i[13] ^ bl_s);
        bl_i2         = ~(instr_i[11] ^ bl_s);
        bl_offset     = {bl_s, bl_i1, bl_i2, prefix_q[9:0], instr_i[10:0], 1'b0};
        cond_offset   = {instr_i[7:0], 1'b0};
        uncond_offset = {instr_i[10:0], 1'b0};
    end

    always_comb begin
        case (cls_i)
            CLS_SHIFT_IMM: begin
                imm_o = WORD'(instr_i[10:6]);
            end
            CLS_ADD_SUB_IMM3: begin
                imm_o = WORD'(instr_i[8:6]);
            end
            CLS_IMM8: begin
                imm_o = WORD'(instr_i[7:0]);
            end
            CLS_ADR, CLS_LOAD_LIT, CLS_LS_SP: begin
                // word aligned offsets scaled by four
                imm_o = WORD'({instr_i[7:0], 2'b00});
            end
            CLS_DATA_PROC: begin
                // the reverse subtract takes its zero operand from here
                imm_o = '0;
            end
            CLS_LS_WORD_IMM: begin
                imm_o = WORD'({instr_i[10:6], 2'b00});
            end
            CLS_LS_BYTE_IMM: begin
                imm_o = WORD'(instr_i[10:6]);
            end
            CLS_LS_HALF_IMM: begin
                imm_o = WORD'({instr_i[10:6], 1'b0});
            end
            CLS_ADD_SP, CLS_SP_ADJ: begin
                imm_o = WORD'({instr_i[6:0], 2'b00});
            end
            CLS_COND_BRANCH: begin
                imm_o = {{(WORD-COND_OFFSET_W){cond_offset[COND_OFFSET_W-1]}}, cond_offset};
            end
            CLS_UNCOND_BRANCH: begin
                imm_o = {{(WORD-UNCOND_OFFSET_W){uncond_offset[UNCOND_OFFSET_W-1]}},
                         uncond_offset};
            end
            CLS_BL: begin
                imm_o = {{(WORD-BL_OFFSET_W){bl_offset[BL_OFFSET_W-1]}}, bl_offset};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

    // every accepted halfword is kept so that a BL second half finds its prefix
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prefix_q <= '0;
        end else if (instr_valid_i) begin
            prefix_q <= instr_i;
        end
    end

endmodule

//--- logic/thumb_field_decoder.sv
`timescale 1ns/1ns

module thumb_field_decoder (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [thumb_pkg::HALF_WORD-1:0] instr_i,
    input  logic                            instr_valid_i,
    output thumb_pkg::decoded_t             fields_o,
    output logic                            prefix_pending_o
);
    import thumb_pkg::*;

    logic [5:0]       op;
    instr_class_e     cls;
    logic             pending_q;

    logic [REG_W-1:0] lo_rd;
    logic [REG_W-1:0] lo_rn;
    logic [REG_W-1:0] lo_rm;
    logic [REG_W-1:0] hi_rd;

    // format map on the top six bits, first match wins
    always_comb begin
        op  = instr_i[15:10];
        cls = CLS_OTHER;
        casez (op)
            6'b00011?: begin
                // bit 10 selects the imm3 form over the register form
                if (instr_i[10]) begin
                    cls = CLS_ADD_SUB_IMM3;
                end else begin
                    cls = CLS_ADD_SUB_REG;
                end
            end
            6'b000???: cls = CLS_SHIFT_IMM;
            6'b001???: cls = CLS_IMM8;
            6'b010000: cls = CLS_DATA_PROC;
            6'b01001?: cls = CLS_LOAD_LIT;
            6'b0101??: cls = CLS_LS_REG;
            6'b0110??: cls = CLS_LS_WORD_IMM;
            6'b0111??: cls = CLS_LS_BYTE_IMM;
            6'b1000??: cls = CLS_LS_HALF_IMM;
            6'b1001??: cls = CLS_LS_SP;
            6'b10100?: cls = CLS_ADR;
            6'b10101?: cls = CLS_ADD_SP;
            6'b101100: begin
                // only 1011_0000 is the SP adjust, the rest of misc stays other
                if (instr_i[9:8] == 2'b00) begin
                    cls = CLS_SP_ADJ;
                end
            end
            6'b1101??: begin
                // condition codes 1110 and 1111 encode udf and svc
                if (instr_i[11:9] != 3'b111) begin
                    cls = CLS_COND_BRANCH;
                end
            end
            6'b11100?: cls = CLS_UNCOND_BRANCH;
            6'b11110?: cls = CLS_BL_PREFIX;
            6'b11111?, 6'b11101?: begin
                if (pending_q) begin
                    cls = CLS_BL;
                end else begin
                    cls = CLS_ILLEGAL;
                end
            end
            default: cls = CLS_OTHER;
        endcase
    end

    // candidate register fields for the low and high register layouts
    always_comb begin
        lo_rd = REG_W'(instr_i[2:0]);
        lo_rn = REG_W'(instr_i[5:3]);
        lo_rm = REG_W'(instr_i[8:6]);
        hi_rd = REG_W'(instr_i[10:8]);
    end

    always_comb begin
        fields_o     = '0;
        fields_o.cls = cls;
        case (cls)
            CLS_SHIFT_IMM, CLS_ADD_SUB_IMM3, CLS_DATA_PROC,
            CLS_LS_WORD_IMM, CLS_LS_BYTE_IMM, CLS_LS_HALF_IMM: begin
                fields_o.rd = lo_rd;
                fields_o.rn = lo_rn;
            end
            CLS_ADD_SUB_REG, CLS_LS_REG: begin
                fields_o.rd = lo_rd;
                fields_o.rn = lo_rn;
                fields_o.rm = lo_rm;
            end
            CLS_IMM8: begin
                // add, sub and cmp read the same register they name as rd
                fields_o.rd = hi_rd;
                fields_o.rn = hi_rd;
            end
            CLS_LOAD_LIT, CLS_ADR: begin
                fields_o.rd = hi_rd;
                fields_o.rn = REG_PC;
            end
            CLS_LS_SP, CLS_ADD_SP: begin
                fields_o.rd = hi_rd;
                fields_o.rn = REG_SP;
            end
            CLS_SP_ADJ: begin
                fields_o.rd = REG_SP;
                fields_o.rn = REG_SP;
            end
            CLS_COND_BRANCH: begin
                fields_o.cond = instr_i[11:8];
            end
            default: begin
                fields_o.rd = '0;
            end
        endcase
    end

    // any accepted halfword other than a prefix ends the pending state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (instr_valid_i) begin
            pending_q <= (cls == CLS_BL_PREFIX);
        end
    end

    assign prefix_pending_o = pending_q;

endmodule

//--- logic/decode_register.sv
`timescale 1ns/1ns

module decode_register (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       instr_valid_i,
    input  thumb_pkg::decoded_t        fields_i,
    input  logic [thumb_pkg::WORD-1:0] imm_i,
    output thumb_pkg::decoded_t        dec_o,
    output logic                       dec_valid_o
);
    import thumb_pkg::*;

    decoded_t merged;
    decoded_t dec_q;
    logic     emit;
    logic     dec_valid_q;

    // the field decoder leaves imm at zero, so the generated value goes in here
    always_comb begin
        merged     = fields_i;
        merged.imm = imm_i;
    end

    // a BL prefix only primes the next halfword and gives no result of its own
    assign emit = instr_valid_i && (fields_i.cls != CLS_BL_PREFIX);

    always_ff @(posedge clk_i) begin
        if (emit) begin
            dec_q <= merged;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= emit;
        end
    end

    assign dec_o       = dec_q;
    assign dec_valid_o = dec_valid_q;

endmodule

//--- logic/thumb_decode_top.sv
`timescale 1ns/1ns

module thumb_decode_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [thumb_pkg::HALF_WORD-1:0] instr_i,
    input  logic                            instr_valid_i,
    output thumb_pkg::decoded_t             dec_o,
    output logic                            dec_valid_o
);
    import thumb_pkg::*;

    decoded_t         fields;
    logic [WORD-1:0]  imm;

    // the pending level is consumed inside the field decoder itself
    thumb_field_decoder i_field_decoder (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .instr_i          (instr_i),
        .instr_valid_i    (instr_valid_i),
        .fields_o         (fields),
        .prefix_pending_o ()
    );

    thumb_imm_gen i_imm_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .cls_i         (fields.cls),
        .imm_o         (imm)
    );

    decode_register i_decode_register (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .fields_i      (fields),
        .imm_i         (imm),
        .dec_o         (dec_o),
        .dec_valid_o   (dec_valid_o)
    );

endmodule

//--- tests/tb_thumb_decode.sv
`timescale 1ns/1ns

module tb_thumb_decode;
    import thumb_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ENTRIES = 30;
    localparam int RAND_LEN    = NUM_ENTRIES;
    localparam int WATCH_CYCLES = (NUM_ENTRIES + RAND_LEN) * 4;
    localparam logic [31:0] RAND_SEED = 32'he3ebbf9f;

    // one stimulus halfword with the result it must produce
    typedef struct packed {
        logic [HALF_WORD-1:0] instr;
        logic                 has_result;
        instr_class_e         cls;
        logic [REG_W-1:0]     rd;
        logic [REG_W-1:0]     rn;
        logic [WORD-1:0]      imm;
    } entry_t;

    // an outstanding result, with the time its pulse must be seen
    typedef struct packed {
        entry_t      ent;
        logic [63:0] due;
        logic [31:0] seq;
    } want_t;

    logic                 clk_i;
    logic                 rst_n_i;
    logic [HALF_WORD-1:0] instr_i;
    logic                 instr_valid_i;
    decoded_t             dec_o;
    logic                 dec_valid_o;

    entry_t stim [NUM_ENTRIES];
    want_t  pending_q[$];
    int     seq_num;
    int     ok_count;
    int     fail_count;
    int     error_count;

    thumb_decode_top i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .dec_o         (dec_o),
        .dec_valid_o   (dec_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic entry_t make_entry(input logic [15:0] instr, input logic has_result,
                                          input instr_class_e cls, input logic [3:0] rd,
                                          input logic [3:0] rn, input logic [31:0] imm);
        entry_t e;
        e.instr      = instr;
        e.has_result = has_result;
        e.cls        = cls;
        e.rd         = rd;
        e.rn         = rn;
        e.imm        = imm;
        return e;
    endfunction

    // expected values are worked out by hand from the Thumb encodings
    task automatic load_table();
        stim[0]  = make_entry(16'h0151, 1'b1, CLS_SHIFT_IMM, 4'd1, 4'd2, 32'h5);
        stim[1]  = make_entry(16'h1DE3, 1'b1, CLS_ADD_SUB_IMM3, 4'd3, 4'd4, 32'h7);
        stim[2]  = make_entry(16'h1888, 1'b1, CLS_ADD_SUB_REG, 4'd0, 4'd1, 32'h0);
        stim[3]  = make_entry(16'h25A5, 1'b1, CLS_IMM8, 4'd5, 4'd5, 32'hA5);
        stim[4]  = make_entry(16'h425E, 1'b1, CLS_DATA_PROC, 4'd6, 4'd3, 32'h0);
        stim[5]  = make_entry(16'h4A13, 1'b1, CLS_LOAD_LIT, 4'd2, 4'd15, 32'h4C);
        stim[6]  = make_entry(16'h6FC8, 1'b1, CLS_LS_WORD_IMM, 4'd0, 4'd1, 32'h7C);
        stim[7]  = make_entry(16'h70FA, 1'b1, CLS_LS_BYTE_IMM, 4'd2, 4'd7, 32'h3);
        stim[8]  = make_entry(16'h8D65, 1'b1, CLS_LS_HALF_IMM, 4'd5, 4'd4, 32'h2A);
        stim[9]  = make_entry(16'h9FFF, 1'b1, CLS_LS_SP, 4'd7, 4'd13, 32'h3FC);
        stim[10] = make_entry(16'hA180, 1'b1, CLS_ADR, 4'd1, 4'd15, 32'h200);
        stim[11] = make_entry(16'hAC05, 1'b1, CLS_ADD_SP, 4'd4, 4'd13, 32'h14);
        stim[12] = make_entry(16'hB07F, 1'b1, CLS_SP_ADJ, 4'd13, 4'd13, 32'h1FC);
        stim[13] = make_entry(16'hB081, 1'b1, CLS_SP_ADJ, 4'd13, 4'd13, 32'h4);
        stim[14] = make_entry(16'hD1FE, 1'b1, CLS_COND_BRANCH, 4'd0, 4'd0, 32'hFFFFFFFC);
        stim[15] = make_entry(16'hDC80, 1'b1, CLS_COND_BRANCH, 4'd0, 4'd0, 32'hFFFFFF00);
        stim[16] = make_entry(16'hD010, 1'b1, CLS_COND_BRANCH, 4'd0, 4'd0, 32'h20);
        stim[17] = make_entry(16'hE7FF, 1'b1, CLS_UNCOND_BRANCH, 4'd0, 4'd0, 32'hFFFFFFFE);
        stim[18] = make_entry(16'hE400, 1'b1, CLS_UNCOND_BRANCH, 4'd0, 4'd0, 32'hFFFFF800);
        // BL pairs, the first with S clear and the other two with S set
        stim[19] = make_entry(16'hF001, 1'b0, CLS_BL_PREFIX, 4'd0, 4'd0, 32'h0);
        stim[20] = make_entry(16'hF923, 1'b1, CLS_BL, 4'd0, 4'd0, 32'h1246);
        stim[21] = make_entry(16'hF7FF, 1'b0, CLS_BL_PREFIX, 4'd0, 4'd0, 32'h0);
        stim[22] = make_entry(16'hFFFE, 1'b1, CLS_BL, 4'd0, 4'd0, 32'hFFFFFFFC);
        stim[23] = make_entry(16'hF400, 1'b0, CLS_BL_PREFIX, 4'd0, 4'd0, 32'h0);
        stim[24] = make_entry(16'hE800, 1'b1, CLS_BL, 4'd0, 4'd0, 32'hFFC00000);
        // a second half with nothing in front, then a prefix broken by a mov
        stim[25] = make_entry(16'hF923, 1'b1, CLS_ILLEGAL, 4'd0, 4'd0, 32'h0);
        stim[26] = make_entry(16'hF001, 1'b0, CLS_BL_PREFIX, 4'd0, 4'd0, 32'h0);
        stim[27] = make_entry(16'h25A5, 1'b1, CLS_IMM8, 4'd5, 4'd5, 32'hA5);
        stim[28] = make_entry(16'hFFFE, 1'b1, CLS_ILLEGAL, 4'd0, 4'd0, 32'h0);
        stim[29] = make_entry(16'hBF00, 1'b1, CLS_OTHER, 4'd0, 4'd0, 32'h0);
    endtask

    // called on a rising edge, the DUT samples the strobe one edge later
    task automatic apply_entry(input int idx);
        want_t w;
        instr_i       <= stim[idx].instr;
        instr_valid_i <= 1'b1;
        if (stim[idx].has_result) begin
            w.ent = stim[idx];
            w.due = $time + CLK_PERIOD + CLK_PERIOD / 2;
            w.seq = seq_num;
            seq_num++;
            pending_q.push_back(w);
        end
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] want_v,
                                 input logic [31:0] got_v);
        $display("ERROR t=%0t %s expected %h got %h", $time, name, want_v, got_v);
        error_count++;
    endtask

    task automatic report_test(input want_t w, input logic bad);
        if (bad) begin
            $display("test %0d instr %h failed", w.seq, w.ent.instr);
            fail_count++;
        end else begin
            $display("test %0d instr %h ok", w.seq, w.ent.instr);
            ok_count++;
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk_i) begin : check_results
        want_t      w;
        logic       bad;
        logic [3:0] want_cond;
        logic [3:0] want_rm;
        if (dec_valid_o === 1'b1) begin
            if (pending_q.size() == 0) begin
                $display("at %0t dec_valid_o pulsed while no result was outstanding", $time);
                error_count++;
                fail_count++;
            end else begin
                w   = pending_q.pop_front();
                bad = 1'b0;
                want_cond = (w.ent.cls == CLS_COND_BRANCH) ? w.ent.instr[11:8] : 4'd0;
                // only the three-register formats carry rm in bits 8:6
                if (w.ent.cls == CLS_ADD_SUB_REG || w.ent.cls == CLS_LS_REG) begin
                    want_rm = {1'b0, w.ent.instr[8:6]};
                end else begin
                    want_rm = 4'd0;
                end
                if (w.due != $time) begin
                    $display("at %0t result for instr %h came at the wrong cycle, due at %0t",
                             $time, w.ent.instr, w.due);
                    error_count++;
                    bad = 1'b1;
                end
                if (dec_o.cls != w.ent.cls) begin
                    show_mismatch("dec_o.cls", 32'(w.ent.cls), 32'(dec_o.cls));
                    bad = 1'b1;
                end
                if (dec_o.rd != w.ent.rd) begin
                    show_mismatch("dec_o.rd", 32'(w.ent.rd), 32'(dec_o.rd));
                    bad = 1'b1;
                end
                if (dec_o.rn != w.ent.rn) begin
                    show_mismatch("dec_o.rn", 32'(w.ent.rn), 32'(dec_o.rn));
                    bad = 1'b1;
                end
                if (dec_o.rm != want_rm) begin
                    show_mismatch("dec_o.rm", 32'(want_rm), 32'(dec_o.rm));
                    bad = 1'b1;
                end
                if (dec_o.cond != want_cond) begin
                    show_mismatch("dec_o.cond", 32'(want_cond), 32'(dec_o.cond));
                    bad = 1'b1;
                end
                if (dec_o.imm != w.ent.imm) begin
                    show_mismatch("dec_o.imm", w.ent.imm, dec_o.imm);
                    bad = 1'b1;
                end
                report_test(w, bad);
            end
        end else if (pending_q.size() != 0 && pending_q[0].due <= $time) begin
            w = pending_q.pop_front();
            $display("at %0t no result appeared for instr %h at its expected cycle",
                     $time, w.ent.instr);
            error_count++;
            report_test(w, 1'b1);
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : drive_stimulus
        int   gap;
        logic reset_bad;
        rst_n_i       = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        seq_num       = 0;
        ok_count      = 0;
        fail_count    = 0;
        error_count   = 0;
        void'($urandom(RAND_SEED));
        load_table();

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        reset_bad = 1'b0;
        if (dec_valid_o !== 1'b0) begin
            $display("ERROR t=%0t dec_valid_o expected 0 got %b", $time, dec_valid_o);
            error_count++;
            reset_bad = 1'b1;
        end
        if (i_dut.i_field_decoder.prefix_pending_o !== 1'b0) begin
            $display("ERROR t=%0t prefix_pending_o expected 0 got %b", $time,
                     i_dut.i_field_decoder.prefix_pending_o);
            error_count++;
            reset_bad = 1'b1;
        end
        if (reset_bad) begin
            fail_count++;
            $display("test reset failed");
        end else begin
            ok_count++;
            $display("test reset ok");
        end

        // back-to-back strobes through the whole table
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk_i);
            apply_entry(i);
        end

        // same table again with random idle cycles between strobes
        for (int i = 0; i < RAND_LEN; i++) begin
            gap = int'($urandom_range(3, 0));
            repeat (gap) begin
                @(posedge clk_i);
                instr_valid_i <= 1'b0;
            end
            @(posedge clk_i);
            apply_entry(i);
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        if (pending_q.size() != 0) begin
            $display("%0d results never appeared after the last strobe", pending_q.size());
            error_count++;
            fail_count++;
        end

        $display("summary: %0d ok, %0d bad, %0d errors", ok_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
logic/thumb_pkg.sv
logic/thumb_imm_gen.sv
logic/thumb_field_decoder.sv
logic/decode_register.sv
logic/thumb_decode_top.sv
tests/tb_thumb_decode.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f build.f \
    --top-module tb_thumb_decode -Mdir obj_dir -o tb_thumb_decode

output=$(./obj_dir/tb_thumb_decode)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
